// ==== vlog.f ====
common/multiHPkg.sv
common/mfBus.sv
common/metricBus.sv
mfilt/mfiltBank.sv
src/rotator.sv
src/decisionMultiH.sv
src/trellisMultiH.sv
tests/clockGen.sv
tests/trellisMultiH_checker.sv
tests/test.sv

// ==== runSim.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module test -o simTest \
   && ./obj_dir/simTest | tee /dev/stderr | grep -q "Result: PASSED" \
   && echo "simulation run ok" \
   || { echo "simulation run failed"; exit 1; }

// ==== tests/test.sv ====
`default_nettype none

module test import multiHPkg::*; ();

   timeunit 1ns;
   timeprecision 1ns;

   localparam int clockPeriod = 40;
   localparam int numDirected = 16;
   localparam int numRandom = 24;
   localparam int numRows = numDirected + numRandom;
   // 8 cycles per symbol plus reset and margin
   localparam int watchdogCycles = numRows * 8 + 4 + 20;

   // --------------------------------------------------
   // directed table, scale 0 is the all-zero tie row
   // --------------------------------------------------

   // ordered so each symbol is seen once at phase 0 with hIdx0
   localparam quatSym_t dirSym [numDirected] = '{
      symP3, symP1, symP1, symM1, symM1, symP1, symM3, symM1,
      symP3, symP3, symM3, symM3, symP3, symM1, symP1, symM3
   };
   localparam int dirScale [numDirected] = '{
      400, 300, 350, 250, 400, 320, 380, 300,
      420, 260, 330, 410, 0, 290, 370, 310
   };

   logic clk;
   logic reset;
   logic symEn;
   logic sym2xEn;
   logic signed [sampleW-1:0] iIn;
   logic signed [sampleW-1:0] qIn;
   quatSym_t decision;
   logic decisionEn;
   phase_t symPhase;

   // row table, samples before rotation
   int rowI0 [numRows];
   int rowQ0 [numRows];
   int rowI1 [numRows];
   int rowQ1 [numRows];
   quatSym_t rowSym [numRows];
   bit rowByModel [numRows];

   int seed = 61868;
   int errorCount = 0;
   int testsRun = 0;
   int testsFailed = 0;
   int pulseCount = 0;
   bit curFailed;

   // model state
   phase_t modelPhase = '0;
   hIdx_t modelH = hIdx0;

   clockGen clockGen_inst (
      .clk   (clk),
      .reset (reset)
   );

   trellisMultiH trellisMultiH_inst (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .sym2xEn    (sym2xEn),
      .iIn        (iIn),
      .qIn        (qIn),
      .decision   (decision),
      .decisionEn (decisionEn),
      .symPhase   (symPhase)
   );

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------

   // phase advance in quarter turns
   function automatic phase_t stepFor(input hIdx_t h, input quatSym_t s);
      if (h == hIdx0) begin
         return (s == symP3 || s == symM1) ? 2'd3 : 2'd1;
      end
      case (s)
         symP1: return 2'd1;
         symM1: return 2'd3;
         default: return 2'd2;
      endcase
   endfunction

   // multiply by j^p
   function automatic void rotateBy(input phase_t p, inout int iv, inout int qv);
      int t;
      t = iv;
      case (p)
         2'd1: begin
            iv = -qv;
            qv = t;
         end
         2'd2: begin
            iv = -iv;
            qv = -qv;
         end
         2'd3: begin
            iv = qv;
            qv = -t;
         end
         default: begin
         end
      endcase
   endfunction

   // correlate, derotate, keep the largest real part
   function automatic quatSym_t predictSymbol(input int i0, input int q0,
      input int i1, input int q1, input phase_t p);
      longint re;
      longint im;
      longint metric;
      longint best;
      int bestIdx;
      best = 0;
      bestIdx = 0;
      for (int h = 0; h < numHyp; h++) begin
         re = longint'(i0) * longint'(mfCoeffI[h][0]) + longint'(q0) * longint'(mfCoeffQ[h][0])
            + longint'(i1) * longint'(mfCoeffI[h][1]) + longint'(q1) * longint'(mfCoeffQ[h][1]);
         im = longint'(q0) * longint'(mfCoeffI[h][0]) - longint'(i0) * longint'(mfCoeffQ[h][0])
            + longint'(q1) * longint'(mfCoeffI[h][1]) - longint'(i1) * longint'(mfCoeffQ[h][1]);
         case (p)
            2'd0: metric = re;
            2'd1: metric = im;
            2'd2: metric = -re;
            default: metric = -im;
         endcase
         // ties keep the lower index
         if (h == 0 || metric > best) begin
            best = metric;
            bestIdx = h;
         end
      end
      return quatSym_t'(2'(bestIdx));
   endfunction

   function automatic void buildTable();
      quatSym_t s;
      int scale;
      for (int r = 0; r < numDirected; r++) begin
         rowI0[r] = dirScale[r] * int'(mfCoeffI[dirSym[r]][0]);
         rowQ0[r] = dirScale[r] * int'(mfCoeffQ[dirSym[r]][0]);
         rowI1[r] = dirScale[r] * int'(mfCoeffI[dirSym[r]][1]);
         rowQ1[r] = dirScale[r] * int'(mfCoeffQ[dirSym[r]][1]);
         rowSym[r] = dirSym[r];
         rowByModel[r] = 1'b0;
      end
      // scaled reference plus small offsets, expected filled in by the model
      for (int r = numDirected; r < numRows; r++) begin
         s = quatSym_t'(2'($random(seed)));
         scale = 100 + ($random(seed) & 255);
         rowI0[r] = scale * int'(mfCoeffI[s][0]) + $random(seed) % 32;
         rowQ0[r] = scale * int'(mfCoeffQ[s][0]) + $random(seed) % 32;
         rowI1[r] = scale * int'(mfCoeffI[s][1]) + $random(seed) % 32;
         rowQ1[r] = scale * int'(mfCoeffQ[s][1]) + $random(seed) % 32;
         rowSym[r] = s;
         rowByModel[r] = 1'b1;
      end
   endfunction

   // --------------------------------------------------
   // compare tasks
   // --------------------------------------------------

   task automatic checkSym(input string sigName, input quatSym_t got, input quatSym_t exp);
      if (got !== exp) begin
         $display("Error: %s got 0x%h expected 0x%h", sigName, got, exp);
         curFailed = 1'b1;
      end
   endtask

   task automatic checkPhase(input string sigName, input phase_t got, input phase_t exp);
      if (got !== exp) begin
         $display("Error: %s got 0x%h expected 0x%h", sigName, got, exp);
         curFailed = 1'b1;
      end
   endtask

   task automatic finishTest(input string label);
      testsRun++;
      if (curFailed) begin
         testsFailed++;
         errorCount++;
         $display("%s failed", label);
      end else begin
         $display("%s ok", label);
      end
      curFailed = 1'b0;
   endtask

   // --------------------------------------------------
   // stimulus, one symbol every 8 cycles
   // --------------------------------------------------

   // called just after a rising edge, returns on the edge that shows decisionEn
   task automatic applyRow(input int r);
      int i0;
      int q0;
      int i1;
      int q1;
      quatSym_t expSym;
      i0 = rowI0[r];
      q0 = rowQ0[r];
      i1 = rowI1[r];
      q1 = rowQ1[r];
      // pre-rotate by the carrier phase the DUT should be tracking
      rotateBy(modelPhase, i0, q0);
      rotateBy(modelPhase, i1, q1);
      expSym = rowByModel[r] ? predictSymbol(i0, q0, i1, q1, modelPhase) : rowSym[r];
      iIn <= sampleW'(i0);
      qIn <= sampleW'(q0);
      sym2xEn <= 1'b1;
      @(posedge clk);
      sym2xEn <= 1'b0;
      repeat (3) @(posedge clk);
      iIn <= sampleW'(i1);
      qIn <= sampleW'(q1);
      sym2xEn <= 1'b1;
      symEn <= 1'b1;
      @(posedge clk);
      sym2xEn <= 1'b0;
      symEn <= 1'b0;
      do begin
         @(posedge clk);
      end while (!decisionEn);
      modelPhase = modelPhase + stepFor(modelH, expSym);
      modelH = (modelH == hIdx0) ? hIdx1 : hIdx0;
      checkSym("decision", decision, expSym);
      checkPhase("symPhase", symPhase, modelPhase);
   endtask

   // one pulse per symbol expected
   always @(posedge clk) begin
      if (decisionEn) begin
         pulseCount++;
      end
   end

   initial begin
      symEn = 1'b0;
      sym2xEn = 1'b0;
      iIn = '0;
      qIn = '0;
      curFailed = 1'b0;
      buildTable();
      @(posedge clk);
      while (reset) begin
         @(posedge clk);
      end
      // quiet after reset until the first symbol
      repeat (2) begin
         @(posedge clk);
         if (decisionEn !== 1'b0) begin
            $display("Error: decisionEn got 0x%h expected 0x0", decisionEn);
            curFailed = 1'b1;
         end
         checkPhase("symPhase", symPhase, 2'd0);
         checkSym("decision", decision, symP3);
      end
      finishTest("reset state");
      for (int r = 0; r < numRows; r++) begin
         applyRow(r);
         finishTest($sformatf("row %0d", r));
      end
      @(posedge clk);
      if (pulseCount != numRows) begin
         $display("Error: decisionEn pulses got 0x%h expected 0x%h", pulseCount, numRows);
         curFailed = 1'b1;
      end
      if (trellisMultiH_inst.trellisMultiH_checker_inst.failCount != 0) begin
         $display("bound checker reported failed assertions");
         curFailed = 1'b1;
      end
      finishTest("pulse count");
      $display("%0d tests, %0d passed, %0d failed", testsRun, testsRun - testsFailed,
         testsFailed);
      if (errorCount == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // watchdog, sized from the row count
   initial begin
      #(watchdogCycles * clockPeriod);
      $display("timeout, no decision arrived from the DUT in time");
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/trellisMultiH_checker.sv ====
`default_nettype none

module trellisMultiH_checker (
   input logic clk,
   input logic reset,
   input logic symEn,
   input logic sym2xEn,
   input logic decisionEn
);

   timeunit 1ns;
   timeprecision 1ns;

   // failed assertions, read back by the testbench at the end
   int failCount = 0;

   // --------------------------------------------------
   // strobe rules
   // --------------------------------------------------

   // second half strobe always rides on sym2xEn
   symOnSym2x: assert property (@(posedge clk) disable iff (reset) symEn |-> sym2xEn)
      else begin
         $error("symEn high without sym2xEn");
         failCount++;
      end

   // phase feedback needs 4 cycles between symbols
   symSpacing: assert property (@(posedge clk) disable iff (reset)
      symEn |-> !$past(symEn, 1) && !$past(symEn, 2) && !$past(symEn, 3))
      else begin
         $error("symEn strobes closer than 4 cycles");
         failCount++;
      end

   // --------------------------------------------------
   // pipeline latency and reset
   // --------------------------------------------------

   // filter bank, rotator, decision: one cycle each
   decLatency: assert property (@(posedge clk) disable iff (reset) symEn |-> ##3 decisionEn)
      else begin
         $error("decisionEn not 3 cycles after symEn");
         failCount++;
      end

   decQuietInReset: assert property (@(posedge clk) reset |=> !decisionEn)
      else begin
         $error("decisionEn high after a reset cycle");
         failCount++;
      end

endmodule

bind trellisMultiH trellisMultiH_checker trellisMultiH_checker_inst (
   .clk        (clk),
   .reset      (reset),
   .symEn      (symEn),
   .sym2xEn    (sym2xEn),
   .decisionEn (decisionEn)
);

`default_nettype wire

// ==== tests/clockGen.sv ====
`default_nettype none

module clockGen (
   output logic clk,
   output logic reset
);

   timeunit 1ns;
   timeprecision 1ns;

   // 40 ns period
   localparam int halfPeriod = 20;
   localparam int resetCycles = 4;

   initial begin
      clk = 1'b0;
      forever #(halfPeriod) clk = ~clk;
   end

   // synchronous reset, released on an edge
   initial begin
      reset = 1'b1;
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== src/trellisMultiH.sv ====
`default_nettype none

module trellisMultiH import multiHPkg::*; (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      symEn,
   input  logic                      sym2xEn,
   input  logic signed [sampleW-1:0] iIn,
   input  logic signed [sampleW-1:0] qIn,
   output quatSym_t                  decision,
   output logic                      decisionEn,
   output phase_t                    symPhase
);

   // --------------------------------------------------
   // stage links
   // --------------------------------------------------

   // correlations, filter bank to rotator
   mfBus mfIf ();

   // metrics, rotator to decision
   metricBus metIf ();

   // --------------------------------------------------
   // pipeline, three registered stages
   // --------------------------------------------------

   mfiltBank mfiltBank_inst (
      .clk     (clk),
      .reset   (reset),
      .symEn   (symEn),
      .sym2xEn (sym2xEn),
      .iIn     (iIn),
      .qIn     (qIn),
      .mf      (mfIf.src)
   );

   // symPhase fed back from the decision stage
   rotator rotator_inst (
      .clk      (clk),
      .reset    (reset),
      .symPhase (symPhase),
      .mf       (mfIf.dst),
      .met      (metIf.src)
   );

   decisionMultiH decisionMultiH_inst (
      .clk        (clk),
      .reset      (reset),
      .met        (metIf.dst),
      .decision   (decision),
      .decisionEn (decisionEn),
      .symPhase   (symPhase)
   );

endmodule

`default_nettype wire

// ==== src/decisionMultiH.sv ====
`default_nettype none

module decisionMultiH import multiHPkg::*; (
   input  logic     clk,
   input  logic     reset,
   metricBus.dst    met,
   output quatSym_t decision,
   output logic     decisionEn,
   output phase_t   symPhase
);

   // index in force for the symbol being decided
   hIdx_t hIdx;

   // compare-select result
   logic [1:0]              bestIdx;
   logic signed [corrW-1:0] bestMetric;

   // phase after this symbol
   phase_t nextPhase;

   // --------------------------------------------------
   // compare-select
   // --------------------------------------------------

   // strict greater-than keeps the lowest index on a tie
   always_comb begin
      bestIdx    = 2'd0;
      bestMetric = met.metric[0];
      for (int h = 1; h < numHyp; h++) begin
         if (met.metric[h] > bestMetric) begin
            bestMetric = met.metric[h];
            bestIdx    = 2'(h);
         end
      end
   end

   // --------------------------------------------------
   // phase advance
   // --------------------------------------------------

   // step depends on both h and the chosen symbol
   // wraps naturally in two bits, i.e. mod 4 quarter turns
   assign nextPhase = symPhase + phaseStep[hIdx][bestIdx];

   // --------------------------------------------------
   // state update
   // --------------------------------------------------

   // decision, phase and h all move on the same edge
   // so symPhase is settled for the rotator well before the next symbol
   always_ff @(posedge clk) begin
      if (reset) begin
         decision   <= symP3;
         decisionEn <= 1'b0;
         symPhase   <= '0;
         hIdx       <= hIdx0;
      end else begin
         decisionEn <= met.metricValid;
         if (met.metricValid) begin
            decision <= quatSym_t'(bestIdx);
            symPhase <= nextPhase;
            // multi-h, alternate every symbol
            hIdx     <= (hIdx == hIdx0) ? hIdx1 : hIdx0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/rotator.sv ====
`default_nettype none

module rotator import multiHPkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  phase_t symPhase,
   mfBus.dst      mf,
   metricBus.src  met
);

   // real part after derotation, one per hypothesis
   logic signed [corrW-1:0] derot [numHyp];

   // --------------------------------------------------
   // quarter-turn derotation
   // --------------------------------------------------

   // multiply by exp(-j*k*pi/2) and keep only the real part
   // so no multiplier needed, just a select and a negate
   always_comb begin
      for (int h = 0; h < numHyp; h++) begin
         case (symPhase)
            2'd0: begin
               derot[h] = mf.corrRe[h];
            end
            2'd1: begin
               // (a+jb)(-j) -> real part b
               derot[h] = mf.corrIm[h];
            end
            2'd2: begin
               derot[h] = -mf.corrRe[h];
            end
            default: begin
               derot[h] = -mf.corrIm[h];
            end
         endcase
      end
   end

   // --------------------------------------------------
   // output register
   // --------------------------------------------------

   // metrics only move when a new correlation lands
   always_ff @(posedge clk) begin
      if (mf.corrValid) begin
         for (int h = 0; h < numHyp; h++) begin
            met.metric[h] <= derot[h];
         end
      end
   end

   // one cycle behind corrValid
   always_ff @(posedge clk) begin
      if (reset) begin
         met.metricValid <= 1'b0;
      end else begin
         met.metricValid <= mf.corrValid;
      end
   end

endmodule

`default_nettype wire

// ==== mfilt/mfiltBank.sv ====
`default_nettype none

module mfiltBank import multiHPkg::*; (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      symEn,
   input  logic                      sym2xEn,
   input  logic signed [sampleW-1:0] iIn,
   input  logic signed [sampleW-1:0] qIn,
   mfBus.src                         mf
);

   // half strobes
   logic firstHalfEn;
   logic lastHalfEn;

   // which reference half applies to the current sample
   logic half;

   // sign-extended samples
   logic signed [corrW-1:0] iExt;
   logic signed [corrW-1:0] qExt;

   // per hypothesis terms of the current half
   logic signed [corrW-1:0] termRe [numHyp];
   logic signed [corrW-1:0] termIm [numHyp];

   // first half partial sums, held until the symbol closes
   logic signed [corrW-1:0] accRe [numHyp];
   logic signed [corrW-1:0] accIm [numHyp];

   // --------------------------------------------------
   // strobe decode
   // --------------------------------------------------

   // symEn always rides on the second sym2xEn of a symbol
   assign firstHalfEn = sym2xEn && !symEn;
   assign lastHalfEn  = sym2xEn && symEn;
   assign half        = symEn;

   assign iExt = corrW'(iIn);
   assign qExt = corrW'(qIn);

   // --------------------------------------------------
   // complex products, r times conj(ref)
   // --------------------------------------------------

   always_comb begin
      logic signed [corrW-1:0] cI;
      logic signed [corrW-1:0] cQ;
      cI = '0;
      cQ = '0;
      for (int h = 0; h < numHyp; h++) begin
         cI = corrW'(mfCoeffI[h][half]);
         cQ = corrW'(mfCoeffQ[h][half]);
         // re = i*cI + q*cQ
         termRe[h] = iExt * cI + qExt * cQ;
         // im = q*cI - i*cQ
         termIm[h] = qExt * cI - iExt * cQ;
      end
   end

   // --------------------------------------------------
   // accumulate over the two halves
   // --------------------------------------------------

   // first half just parks its terms
   always_ff @(posedge clk) begin
      if (firstHalfEn) begin
         for (int h = 0; h < numHyp; h++) begin
            accRe[h] <= termRe[h];
            accIm[h] <= termIm[h];
         end
      end
   end

   // second half closes the correlation
   always_ff @(posedge clk) begin
      if (lastHalfEn) begin
         for (int h = 0; h < numHyp; h++) begin
            mf.corrRe[h] <= accRe[h] + termRe[h];
            mf.corrIm[h] <= accIm[h] + termIm[h];
         end
      end
   end

   // valid one cycle after the symEn edge
   always_ff @(posedge clk) begin
      if (reset) begin
         mf.corrValid <= 1'b0;
      end else begin
         mf.corrValid <= lastHalfEn;
      end
   end

endmodule

`default_nettype wire

// ==== common/metricBus.sv ====
`default_nettype none

// rotator to decision stage, real parts after derotation
interface metricBus import multiHPkg::*; ();

   logic signed [corrW-1:0] metric [numHyp];

   // single cycle strobe
   logic metricValid;

   modport src (
      output metric,
      output metricValid
   );

   modport dst (
      input metric,
      input metricValid
   );

endinterface

`default_nettype wire

// ==== common/mfBus.sv ====
`default_nettype none

// filter bank to rotator, four complex correlations
interface mfBus import multiHPkg::*; ();

   // one correlation per hypothesis
   logic signed [corrW-1:0] corrRe [numHyp];
   logic signed [corrW-1:0] corrIm [numHyp];

   // single cycle, one per symbol
   logic corrValid;

   // filter bank side
   modport src (
      output corrRe,
      output corrIm,
      output corrValid
   );

   // rotator side
   modport dst (
      input corrRe,
      input corrIm,
      input corrValid
   );

endinterface

`default_nettype wire

// ==== common/multiHPkg.sv ====
`default_nettype none

package multiHPkg;

   // --------------------------------------------------
   // datapath widths
   // --------------------------------------------------

   // I and Q sample width from the front end
   localparam int sampleW = 18;

   // signed reference coefficient
   localparam int coeffW = 8;

   // one 18x8 product is 26 bits, two more bits cover the four-term sum
   localparam int corrW = 28;

   // one hypothesis per quaternary symbol
   localparam int numHyp = 4;

   // --------------------------------------------------
   // symbol, phase and h-index types
   // --------------------------------------------------

   // index order doubles as tie-break order, lowest wins
   typedef enum logic [1:0] {
      symP3 = 2'd0,
      symP1 = 2'd1,
      symM1 = 2'd2,
      symM3 = 2'd3
   } quatSym_t;

   // carrier phase in quarter turns
   typedef logic [1:0] phase_t;

   // modulation index in force, alternates every symbol
   typedef enum logic {
      hIdx0 = 1'b0,
      hIdx1 = 1'b1
   } hIdx_t;

   // --------------------------------------------------
   // matched filter references
   // --------------------------------------------------

   // [hypothesis][half], half 0 is the early half-symbol
   // phase trajectories roughly +30/+90, +10/+30, -10/-30, -30/-90 deg
   // scaled to about 100 so every reference has near equal energy
   localparam logic signed [coeffW-1:0] mfCoeffI [numHyp][2] = '{
      '{8'sd87, 8'sd0},
      '{8'sd98, 8'sd87},
      '{8'sd98, 8'sd87},
      '{8'sd87, 8'sd0}
   };

   localparam logic signed [coeffW-1:0] mfCoeffQ [numHyp][2] = '{
      '{8'sd50, 8'sd100},
      '{8'sd17, 8'sd50},
      '{-8'sd17, -8'sd50},
      '{-8'sd50, -8'sd100}
   };

   // --------------------------------------------------
   // phase advance per decided symbol
   // --------------------------------------------------

   // [hIdx][symbol], quarter turns mod 4
   localparam phase_t phaseStep [2][numHyp] = '{
      '{2'd3, 2'd1, 2'd3, 2'd1},
      '{2'd2, 2'd1, 2'd3, 2'd2}
   };

endpackage

`default_nettype wire
